// ==== compile.f ====
verilog/cpuPkg.sv
verilog/stageCounter.sv
verilog/stageTracker.sv
verilog/instrDecoder.sv
verilog/datapath.sv
verilog/wbMaster.sv
verilog/cpuCore.sv
test/wbMemModel.sv
test/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds cpuCoreTb with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f compile.f --top-module cpuCoreTb -o simCpuCore
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simCpuCore)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
	exit 0
fi
echo "Pass line not found"
exit 1

// ==== test/cpuCoreTb.sv ====
//********************
// Program and data share the 256-word model with data at 200 and up
// Base register r7 holds 224, so stores reach 200..255
//********************
`timescale 1ns/1ns
`default_nettype none

module cpuCoreTb;
	import cpuPkg::*;

	localparam int timeoutCycles = 20000;
	localparam logic [15:0] dataBase = 16'd200;	// First data word
	localparam logic [15:0] baseAdr = 16'd224;	// Value kept in r7

	logic clock, rstN;
	logic wbCyc, wbStb, wbWe, wbAck, halted;
	logic [15:0] wbAdr, wbDatW, wbDatR;
	wbReq_t busReq;
	logic [1:0] ackDelay;
	logic [31:0] lcgState;

	logic [15:0] regs [0:7];	// Reference register file
	logic [15:0] expMem [0:255];	// Expected final memory
	logic storeAdr [0:255];	// Addresses the program writes
	logic [7:0] progAdr;
	logic [15:0] jumpAdr;
	int waited;

	// Bus monitor state
	logic prevStb, prevAck, prevWe, anyRequest;
	logic [15:0] prevAdr, prevDatW, lastFetch, expFetch;

	cpuCore UUT (.clock, .rstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR,
		.wbAck, .halted);

	assign busReq = {wbCyc, wbStb, wbWe, wbAdr, wbDatW};

	wbMemModel memModel (.clock, .rstN, .req(busReq), .ackDelay, .datR(wbDatR),
		.ack(wbAck));

	always #4 clock = ~clock;

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic abortWith(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic putWord(input logic [15:0] word);
		memModel.mem[progAdr] = word;
		expMem[progAdr] = word;
		progAdr = progAdr + 8'd1;
	endtask

	// Register-register ALU op and its effect on the reference
	task automatic putRegOp(input opcode_t op, input logic [2:0] rd, rs1, rs2);
		logic [15:0] a, b, r;
		a = regs[rs1];
		b = regs[rs2];
		case (op)
			opSub: r = a - b;
			opAnd: r = a & b;
			opOr: r = a | b;
			default: r = a + b;
		endcase
		putWord({op, rd, rs1, rs2, 3'b000});
		if (rd != 3'd0)
			regs[rd] = r;
	endtask

	// Immediate forms where live low marks a word that is jumped over
	task automatic putImmOp(input opcode_t op, input logic [2:0] rd, rs1,
		input logic [5:0] imm, input logic live);
		logic [15:0] ea;
		ea = regs[rs1] + {{10{imm[5]}}, imm};	// Sum or effective address
		putWord({op, rd, rs1, imm});
		if (live) begin
			case (op)
				opAddi: if (rd != 3'd0) regs[rd] = ea;
				opLoad: if (rd != 3'd0) regs[rd] = expMem[ea[7:0]];
				opStore: begin
					expMem[ea[7:0]] = regs[rd];
					storeAdr[ea[7:0]] = 1'b1;
				end
				default: begin
				end
			endcase
		end
	endtask

	task automatic storeAt(input logic [2:0] rd, input logic [15:0] adr, input logic live);
		putImmOp(opStore, rd, 3'd7, 6'(adr - baseAdr), live);
	endtask

	// Fresh wait count for the memory each clock
	always @(posedge clock) begin
		lcgState = lcgNext(lcgState);
		ackDelay <= lcgState[17:16];
	end

	always @(negedge clock) begin
		if (rstN) begin
			assert (!wbStb || wbCyc) else abortWith("stb is high while cyc is low");
			if (prevStb && !prevAck) begin	// Request still waiting for ack
				assert (wbStb) else abortWith("stb dropped before ack");
				assert (wbAdr === prevAdr)
					else abortWith($sformatf("FAILED wbAdr expected %h got %h", prevAdr, wbAdr));
				assert (wbWe === prevWe)
					else abortWith($sformatf("FAILED wbWe expected %h got %h", prevWe, wbWe));
				assert (wbDatW === prevDatW)
					else abortWith($sformatf("FAILED wbDatW expected %h got %h", prevDatW, wbDatW));
			end
			if (prevAck) begin
				assert (!wbCyc) else abortWith("cyc still high on the clock after ack");
			end
			if (wbStb && wbWe) begin
				assert ((wbAdr[15:8] == 8'd0) && storeAdr[wbAdr[7:0]])
					else abortWith($sformatf("write to %h, an address the program never stores to",
						wbAdr));
			end
			if (wbStb && !prevStb) begin	// New request
				if (!anyRequest) begin
					assert (!wbWe && (wbAdr == 16'd0))
						else abortWith("first bus cycle is not a read at address 0");
				end else if (!wbWe && (wbAdr < dataBase)) begin
					expFetch = (lastFetch == jumpAdr) ? lastFetch + 16'd2 : lastFetch + 16'd1;
					assert (wbAdr === expFetch)
						else abortWith($sformatf("FAILED wbAdr expected %h got %h", expFetch, wbAdr));
				end
				if (!wbWe && (wbAdr < dataBase))
					lastFetch = wbAdr;	// Fetches stay below the data area
				anyRequest = 1'b1;
			end
			if (halted) begin
				assert (!wbCyc) else abortWith("bus cycle started after halted");
			end
			prevStb = wbStb;
			prevAck = wbAck;
			prevWe = wbWe;
			prevAdr = wbAdr;
			prevDatW = wbDatW;
		end
	end

	initial begin
		clock = 1'b0;
		rstN <= 1'b0;
		ackDelay <= 2'd0;
		lcgState = 32'ha5f7b893;
		prevStb = 1'b0;
		prevAck = 1'b0;
		prevWe = 1'b0;
		prevAdr = '0;
		prevDatW = '0;
		anyRequest = 1'b0;
		lastFetch = '0;
		expFetch = '0;

		// Fill depends on every address bit
		for (int i = 0; i < 256; i++) begin
			memModel.mem[8'(i)] = {8'(i) ^ 8'h5c, 8'(i)};
			expMem[8'(i)] = {8'(i) ^ 8'h5c, 8'(i)};
			storeAdr[8'(i)] = 1'b0;
		end
		for (int i = 0; i < 8; i++)
			regs[3'(i)] = '0;
		progAdr = 8'd0;

		putImmOp(opAddi, 3'd7, 3'd0, 6'd28, 1'b1);
		repeat (3) putRegOp(opAdd, 3'd7, 3'd7, 3'd7);	// 28 doubled to 224
		for (int r = 1; r <= 4; r++) begin
			lcgState = lcgNext(lcgState);
			putImmOp(opAddi, 3'(r), 3'd0, lcgState[21:16], 1'b1);
		end
		for (int r = 1; r <= 4; r++)
			storeAt(3'(r), dataBase + 16'(r - 1), 1'b1);
		putRegOp(opAdd, 3'd5, 3'd1, 3'd2);
		storeAt(3'd5, 16'd204, 1'b1);
		putRegOp(opSub, 3'd6, 3'd3, 3'd4);
		storeAt(3'd6, 16'd205, 1'b1);
		putRegOp(opAnd, 3'd5, 3'd1, 3'd3);
		storeAt(3'd5, 16'd206, 1'b1);
		putRegOp(opOr, 3'd6, 3'd2, 3'd4);
		storeAt(3'd6, 16'd207, 1'b1);
		// Round trip through memory, then a sum built on the loaded value
		storeAt(3'd1, 16'd210, 1'b1);
		putImmOp(opLoad, 3'd5, 3'd7, 6'(16'd210 - baseAdr), 1'b1);
		storeAt(3'd5, 16'd214, 1'b1);
		putRegOp(opAdd, 3'd6, 3'd5, 3'd2);
		storeAt(3'd6, 16'd211, 1'b1);
		jumpAdr = {8'd0, progAdr};
		putWord({opJump, 6'd0, 6'd1});	// Skips one word
		storeAt(3'd1, 16'd212, 1'b0);	// Poison store that must never run
		putWord({opNop, 3'd6, 3'd6, 6'd0});	// Fields name r6 so a stray write shows
		storeAt(3'd6, 16'd215, 1'b1);	// r6 unchanged across the nop
		putWord({opHalt, 12'h000});

		@(posedge clock);
		@(negedge clock);
		assert (!wbCyc && !wbStb && !wbWe && !halted)
			else abortWith("bus or halted not low during reset");
		@(posedge clock);
		rstN <= 1'b1;

		waited = 0;
		while (!halted && (waited < timeoutCycles)) begin
			@(negedge clock);
			waited++;
		end
		if (!halted)
			abortWith("halted did not rise before the timeout");
		repeat (20) @(negedge clock);	// Monitor watches for stray cycles

		for (int i = 0; i < 256; i++) begin
			assert (memModel.mem[8'(i)] === expMem[8'(i)])
				else abortWith($sformatf("FAILED mem[%h] expected %h got %h", 8'(i),
					expMem[8'(i)], memModel.mem[8'(i)]));
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/wbMemModel.sv ====
//********************
// 256 words, only adr[7:0] is decoded, one clock ack after 0 to 3 waits
// Contents are preloaded by the testbench through mem
//********************
`timescale 1ns/1ns
`default_nettype none

module wbMemModel (
	input  logic clock,
	input  logic rstN,
	input  cpuPkg::wbReq_t req,
	input  logic [1:0] ackDelay,	// Wait cycles for the next request
	output logic [cpuPkg::dataWidth-1:0] datR,
	output logic ack
);
	import cpuPkg::*;

	logic [dataWidth-1:0] mem [0:255];
	logic waiting;	// Request seen, still counting
	logic [1:0] waitCnt;

	always @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			ack <= 1'b0;
			waiting <= 1'b0;
			waitCnt <= 2'd0;
			datR <= '0;
		end else begin
			ack <= 1'b0;	// Ack lasts one clock
			if (req.cyc && req.stb && !ack) begin
				if (waiting && (waitCnt != 2'd0)) begin
					waitCnt <= waitCnt - 2'd1;
				end else if (!waiting && (ackDelay != 2'd0)) begin
					waiting <= 1'b1;	// Delay latched at request start
					waitCnt <= ackDelay - 2'd1;
				end else begin
					waiting <= 1'b0;
					ack <= 1'b1;
					if (req.we)
						mem[req.adr[7:0]] = req.datW;
					datR <= mem[req.adr[7:0]];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cpuCore.sv ====
//********************
// Single Wishbone master port for code and data, no internal memory
//********************
`timescale 1ns/1ns
`default_nettype none

module cpuCore (
	input  logic clock,
	input  logic rstN,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [cpuPkg::dataWidth-1:0] wbAdr,
	output logic [cpuPkg::dataWidth-1:0] wbDatW,
	input  logic [cpuPkg::dataWidth-1:0] wbDatR,
	input  logic wbAck,
	output logic halted
);
	import cpuPkg::*;

	stage_t stage;
	logic stageAdvance;
	decoded_t decoded;
	logic haltSeen;
	ctlEnables_t enables;
	memCmd_t memCmd;
	logic memDone;
	logic [dataWidth-1:0] rdData;
	logic [dataWidth-1:0] instr;	// IR contents
	logic [dataWidth-1:0] busAdr, busDatW;
	wbReq_t wbOut;

	stageCounter uStageCounter (.clock, .rstN, .memCmd, .memDone, .haltSeen,
		.stage, .stageAdvance, .halted);

	stageTracker uStageTracker (.stage, .decoded, .stageAdvance, .enables, .memCmd);

	instrDecoder uInstrDecoder (.instr, .decoded, .haltSeen);

	datapath uDatapath (.clock, .rstN, .enables, .decoded, .rdData, .instr,
		.busAdr, .busDatW);

	wbMaster uWbMaster (.clock, .rstN, .memCmd, .busAdr, .busDatW, .wbAck, .wbDatR,
		.wbOut, .memDone, .rdData);

	assign wbCyc = wbOut.cyc;
	assign wbStb = wbOut.stb;
	assign wbWe = wbOut.we;
	assign wbAdr = wbOut.adr;
	assign wbDatW = wbOut.datW;

endmodule

`default_nettype wire

// ==== verilog/cpuPkg.sv ====
//********************
// Fixed 16-bit word-addressed ISA, eight registers, r0 reads zero
// Field layout op[15:12] rd[11:9] rs1[8:6] rs2[5:3] and signed imm6 in [5:0]
//********************
`default_nettype none

package cpuPkg;

	localparam int dataWidth = 16;	// Data and word address width
	localparam int regAddrWidth = 3;	// Eight architectural registers
	localparam int opcodeWidth = 4;
	localparam int immWidth = 6;	// Raw immediate before sign extension

	// Numbered from 1 so zero never names a stage
	typedef enum logic [2:0] {
		stFetch = 3'd1,
		stDecode = 3'd2,
		stExecute = 3'd3,
		stMemory = 3'd4,
		stWriteBack = 3'd5,
		stHalted = 3'd6	// Terminal state entered from decode of halt
	} stage_t;

	typedef enum logic [opcodeWidth-1:0] {
		opNop = 4'd0,
		opAdd = 4'd1,
		opSub = 4'd2,
		opAnd = 4'd3,
		opOr = 4'd4,
		opAddi = 4'd5,
		opLoad = 4'd6,
		opStore = 4'd7,
		opJump = 4'd8,	// PC relative to the next instruction
		opHalt = 4'd9
	} opcode_t;

	// Memory and write-back behaviour of an instruction
	typedef enum logic [1:0] {
		accNone = 2'd0,
		accRegWrite = 2'd1,	// ALU result to rd
		accStore = 2'd2,	// RM to mem[RZ]
		accLoad = 2'd3	// mem[RZ] to rd
	} access_t;

	typedef enum logic [1:0] {
		memIdle = 2'd0,
		memRead = 2'd1,
		memWrite = 2'd2
	} memCmd_t;

	typedef struct packed {
		opcode_t opcode;
		logic [regAddrWidth-1:0] rd;
		logic [regAddrWidth-1:0] rs1;
		logic [regAddrWidth-1:0] rs2;	// Holds rd for a store
		logic [dataWidth-1:0] imm;	// Sign extended
		access_t access;
		logic pcLoad;	// Jump loads PC in execute
		logic maSelData;	// Memory stage addresses data via RZ
		logic nop;
	} decoded_t;

	typedef struct packed {
		logic irEn;
		logic pcEn;
		logic raEn;
		logic rbEn;
		logic rzEn;
		logic rmEn;
		logic ryEn;
		logic maSelPc;	// 1 selects PC as bus address, 0 selects RZ
		logic rfWrite;
	} ctlEnables_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [dataWidth-1:0] adr;
		logic [dataWidth-1:0] datW;
	} wbReq_t;

endpackage

`default_nettype wire

// ==== verilog/datapath.sv ====
//********************
// Register file has no reset, program must write before reading
// PC and IR reset to 0 and a NOP
//********************
`timescale 1ns/1ns
`default_nettype none

module datapath (
	input  logic clock,
	input  logic rstN,
	input  cpuPkg::ctlEnables_t enables,
	input  cpuPkg::decoded_t decoded,
	input  logic [cpuPkg::dataWidth-1:0] rdData,
	output logic [cpuPkg::dataWidth-1:0] instr,
	output logic [cpuPkg::dataWidth-1:0] busAdr,
	output logic [cpuPkg::dataWidth-1:0] busDatW
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regFile [0:(1<<regAddrWidth)-1];
	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] ir;
	logic [dataWidth-1:0] ra, rb;	// ALU inputs
	logic [dataWidth-1:0] rz;	// ALU output, also data address
	logic [dataWidth-1:0] rm;	// Store data
	logic [dataWidth-1:0] ry;	// Write-back value
	logic [dataWidth-1:0] rfRead1, rfRead2;
	logic [dataWidth-1:0] aluA, aluB, aluOut;
	logic [dataWidth-1:0] pcNext;

	// r0 is hardwired to zero
	assign rfRead1 = (decoded.rs1 == '0) ? '0 : regFile[decoded.rs1];
	assign rfRead2 = (decoded.rs2 == '0) ? '0 : regFile[decoded.rs2];

	always_comb begin
		aluA = decoded.pcLoad ? pc : ra;	// Jump adds to the already incremented PC
		case (decoded.opcode)
			opAdd, opSub, opAnd, opOr: aluB = rb;
			default: aluB = decoded.imm;	// addi, load, store, jump
		endcase

		case (decoded.opcode)
			opSub: aluOut = aluA - aluB;
			opAnd: aluOut = aluA & aluB;
			opOr: aluOut = aluA | aluB;
			default: aluOut = aluA + aluB;
		endcase
	end

	// irEn is only set in fetch, so it tells increment from jump
	assign pcNext = enables.irEn ? pc + dataWidth'(1) : aluOut;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			ir <= '0;	// Decodes as opNop
		end else begin
			if (enables.pcEn)
				pc <= pcNext;
			if (enables.irEn)
				ir <= rdData;
		end
	end

	always_ff @(posedge clock) begin
		if (enables.raEn)
			ra <= rfRead1;
		if (enables.rbEn)
			rb <= rfRead2;
		if (enables.rzEn)
			rz <= aluOut;
		if (enables.rmEn)
			rm <= rb;
		if (enables.ryEn)
			ry <= (decoded.access == accLoad) ? rdData : rz;	// Load data or ALU result
		if (enables.rfWrite && (decoded.rd != '0))
			regFile[decoded.rd] <= ry;
	end

	assign instr = ir;
	assign busAdr = enables.maSelPc ? pc : rz;
	assign busDatW = rm;

endmodule

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
//********************
// Unknown opcodes decode to no access and no PC load
//********************
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
	input  logic [cpuPkg::dataWidth-1:0] instr,
	output cpuPkg::decoded_t decoded,
	output logic haltSeen
);
	import cpuPkg::*;

	opcode_t opcode;
	logic [regAddrWidth-1:0] rdField;

	assign opcode = opcode_t'(instr[dataWidth-1 -: opcodeWidth]);	// Bits 15..12
	assign rdField = instr[11:9];

	always_comb begin
		decoded = '0;
		decoded.opcode = opcode;
		decoded.rd = rdField;
		decoded.rs1 = instr[8:6];
		// Store data register sits in the rd field
		decoded.rs2 = (opcode == opStore) ? rdField : instr[5:3];
		decoded.imm = {{(dataWidth-immWidth){instr[immWidth-1]}}, instr[immWidth-1:0]};

		case (opcode)
			opAdd, opSub, opAnd, opOr, opAddi: decoded.access = accRegWrite;
			opLoad: decoded.access = accLoad;
			opStore: decoded.access = accStore;
			default: decoded.access = accNone;	// nop, jump, halt
		endcase

		decoded.pcLoad = (opcode == opJump);
		decoded.maSelData = (opcode == opLoad) || (opcode == opStore);
		decoded.nop = (opcode == opNop);
	end

	assign haltSeen = (opcode == opHalt);	// Acted on at the end of decode

endmodule

`default_nettype wire

// ==== verilog/stageCounter.sv ====
//********************
// Stage advances only when no bus command is pending or memDone is seen
// stHalted is left only by reset
//********************
`timescale 1ns/1ns
`default_nettype none

module stageCounter (
	input  logic clock,
	input  logic rstN,
	input  cpuPkg::memCmd_t memCmd,
	input  logic memDone,
	input  logic haltSeen,
	output cpuPkg::stage_t stage,
	output logic stageAdvance,
	output logic halted
);
	import cpuPkg::*;

	stage_t nextStage;

	// Last clock of the current stage
	assign stageAdvance = (memCmd == memIdle) || memDone;

	always_comb begin
		nextStage = stage;
		case (stage)
			stFetch: nextStage = stDecode;
			stDecode: nextStage = haltSeen ? stHalted : stExecute;	// Halt decoded in IR
			stExecute: nextStage = stMemory;
			stMemory: nextStage = stWriteBack;
			stWriteBack: nextStage = stFetch;
			default: nextStage = stHalted;	// Stays put once halted
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			stage <= stFetch;
			halted <= 1'b0;
		end else begin
			if (stageAdvance)
				stage <= nextStage;
			halted <= (stage == stHalted);	// One clock behind the stage
		end
	end

endmodule

`default_nettype wire

// ==== verilog/stageTracker.sv ====
//********************
// Purely combinational with register strobes one clock long at stage end
// memCmd stays constant for the whole stage
//********************
`timescale 1ns/1ns
`default_nettype none

module stageTracker (
	input  cpuPkg::stage_t stage,
	input  cpuPkg::decoded_t decoded,
	input  logic stageAdvance,
	output cpuPkg::ctlEnables_t enables,
	output cpuPkg::memCmd_t memCmd
);
	import cpuPkg::*;

	ctlEnables_t stageEn;	// Ungated pattern of the current stage

	always_comb begin
		stageEn = '0;
		stageEn.maSelPc = 1'b1;	// Address from PC unless memory stage says otherwise
		memCmd = memIdle;

		case (stage)
			stFetch: begin
				stageEn.irEn = 1'b1;	// Instruction word into IR
				stageEn.pcEn = 1'b1;	// PC + 1
				memCmd = memRead;
			end
			stDecode: begin
				// Operand fetch from the register file
				stageEn.raEn = 1'b1;
				stageEn.rbEn = 1'b1;
			end
			stExecute: begin
				stageEn.rzEn = 1'b1;	// ALU result
				stageEn.rmEn = 1'b1;	// Store data
				stageEn.pcEn = decoded.pcLoad;	// Jump target
			end
			stMemory: begin
				stageEn.ryEn = 1'b1;
				stageEn.maSelPc = !decoded.maSelData;
				case (decoded.access)
					accLoad: memCmd = memRead;
					accStore: memCmd = memWrite;
					default: memCmd = memIdle;	// Nothing on the bus
				endcase
			end
			stWriteBack: begin
				stageEn.rfWrite = (decoded.access == accRegWrite) ||
					(decoded.access == accLoad);
			end
			default: begin
				// Halted with everything off
			end
		endcase

		// NOP still fetches, then touches nothing
		if (decoded.nop) begin
			stageEn.raEn = 1'b0;
			stageEn.rbEn = 1'b0;
			stageEn.rzEn = 1'b0;
			stageEn.rmEn = 1'b0;
			stageEn.ryEn = 1'b0;
			stageEn.rfWrite = 1'b0;
		end
	end

	// Strobes fire only on the clock that leaves the stage
	always_comb begin
		enables = stageEn;
		enables.irEn = stageEn.irEn && stageAdvance;
		enables.pcEn = stageEn.pcEn && stageAdvance;
		enables.raEn = stageEn.raEn && stageAdvance;
		enables.rbEn = stageEn.rbEn && stageAdvance;
		enables.rzEn = stageEn.rzEn && stageAdvance;
		enables.rmEn = stageEn.rmEn && stageAdvance;
		enables.ryEn = stageEn.ryEn && stageAdvance;
		enables.rfWrite = stageEn.rfWrite && stageAdvance;
	end

endmodule

`default_nettype wire

// ==== verilog/wbMaster.sv ====
//********************
// Wishbone classic, one transfer per command, no retry or error
// rdData holds until the next read completes
//********************
`timescale 1ns/1ns
`default_nettype none

module wbMaster (
	input  logic clock,
	input  logic rstN,
	input  cpuPkg::memCmd_t memCmd,
	input  logic [cpuPkg::dataWidth-1:0] busAdr,
	input  logic [cpuPkg::dataWidth-1:0] busDatW,
	input  logic wbAck,
	input  logic [cpuPkg::dataWidth-1:0] wbDatR,
	output cpuPkg::wbReq_t wbOut,
	output logic memDone,
	output logic [cpuPkg::dataWidth-1:0] rdData
);
	import cpuPkg::*;

	typedef enum logic {busIdle, busBusy} busState_t;

	busState_t state;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= busIdle;
			wbOut <= '0;
			memDone <= 1'b0;
		end else begin
			memDone <= 1'b0;	// Single clock pulse
			case (state)
				busIdle: begin
					// Command is still up while memDone shows, so skip that clock
					if ((memCmd != memIdle) && !memDone) begin
						wbOut.cyc <= 1'b1;
						wbOut.stb <= 1'b1;
						wbOut.we <= (memCmd == memWrite);
						wbOut.adr <= busAdr;	// Held until ack
						wbOut.datW <= busDatW;
						state <= busBusy;
					end
				end
				busBusy: begin
					if (wbAck) begin
						wbOut.cyc <= 1'b0;
						wbOut.stb <= 1'b0;
						wbOut.we <= 1'b0;
						memDone <= 1'b1;
						state <= busIdle;
					end
				end
				default: state <= busIdle;
			endcase
		end
	end

	// Read data captured on the ack clock
	always_ff @(posedge clock) begin
		if ((state == busBusy) && wbAck)
			rdData <= wbDatR;
	end

endmodule

`default_nettype wire
